/* bram_pkg.sv */
`default_nettype none

package bram_pkg;

	// ==============================
	// Widths and sizes
	// ==============================
	localparam int CPU_ADDR_W   = 11;
	localparam int BYTE_W       = 8;
	localparam int WORD_W       = 16;
	localparam int LBA_W        = 4;
	localparam int BUF_ADDR_W   = 8;
	localparam int RAM_ADDR_W   = LBA_W + BUF_ADDR_W;
	localparam int RAM_DEPTH    = 1 << RAM_ADDR_W; // Entries per byte bank
	localparam int SECTOR_COUNT = 16;
	localparam int HEADER_WORDS = 4;
	localparam int HDR_IDX_W    = $clog2(HEADER_WORDS);

	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
	typedef logic [BYTE_W-1:0]     byte_t;
	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [LBA_W-1:0]      lba_t;
	typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;  // {lba, word index}
	typedef logic [HDR_IDX_W-1:0]  hdr_idx_t;

	// Empty save image signature
	localparam word_t format_header [HEADER_WORDS] = '{
		16'h5548, 16'h4D42, 16'h8800, 16'h8010
	};

	// ==============================
	// Bundles
	// ==============================
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     wdata;
		logic      we;
	} cpu_bram_t;

	typedef struct packed {
		buf_addr_t buff_addr;
		word_t     buff_dout;
		logic      buff_wr;
		logic      ack;
	} host_buf_t;

	typedef struct packed {
		lba_t lba;
		logic rd;  // Load sector from host
		logic wr;  // Save sector to host
	} storage_req_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQUEST,
		ST_TRANSFER,
		ST_NEXT
	} save_state_t;

endpackage

`default_nettype wire

/* backup_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module backup_ram (
	input  wire                      clk_sys,
	input  wire                      arst_n,
	input  wire bram_pkg::cpu_bram_t cpu,
	output bram_pkg::byte_t          cpu_rdata,
	input  wire bram_pkg::host_buf_t host,
	input  wire bram_pkg::lba_t      lba,
	input  wire                      fmt_we,
	input  wire bram_pkg::ram_addr_t fmt_addr,
	input  wire bram_pkg::word_t     fmt_data,
	output bram_pkg::word_t          buff_din
);

	localparam int LANES = 2;

	bram_pkg::ram_addr_t a_addr;
	bram_pkg::ram_addr_t b_addr;
	bram_pkg::word_t     b_wdata;
	logic                b_we;
	logic                a_lane_q;

	// ==============================
	// Port A, console byte access
	// ==============================
	// Bit 0 picks the lane, the rest is the word address
	assign a_addr = {2'b00, cpu.addr[bram_pkg::CPU_ADDR_W-1:1]};

	// Lane of the pending read
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			a_lane_q <= 1'b0;
		else
			a_lane_q <= cpu.addr[0];
	end

	// ==============================
	// Port B, storage or format
	// ==============================
	always_comb begin
		if (fmt_we) begin
			b_addr  = fmt_addr;    // Header words at the bottom
			b_wdata = fmt_data;
		end else begin
			b_addr  = {lba, host.buff_addr};
			b_wdata = host.buff_dout;
		end
	end

	assign b_we = fmt_we | (host.ack & host.buff_wr);

	for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
		bram_pkg::byte_t mem [bram_pkg::RAM_DEPTH];
		bram_pkg::byte_t q_a;
		bram_pkg::byte_t q_b;

		always_ff @(posedge clk_sys) begin
			if (cpu.we && (cpu.addr[0] == 1'(lane)))
				mem[a_addr] <= cpu.wdata;
			if (b_we)
				mem[b_addr] <= b_wdata[lane*bram_pkg::BYTE_W +: bram_pkg::BYTE_W];
			q_a <= mem[a_addr];
			q_b <= mem[b_addr];
		end
	end

	assign cpu_rdata = a_lane_q ? g_lane[1].q_a : g_lane[0].q_a;
	assign buff_din  = {g_lane[1].q_b, g_lane[0].q_b};  // High lane on top

endmodule

`default_nettype wire

/* format_writer.sv */
`timescale 1ns/1ns
`default_nettype none

module format_writer (
	input  wire                  clk_sys,
	input  wire                  arst_n,
	input  wire                  format_cmd,
	output logic                 fmt_we,
	output bram_pkg::ram_addr_t  fmt_addr,
	output bram_pkg::word_t      fmt_data
);

	localparam bram_pkg::hdr_idx_t LAST_IDX =
		bram_pkg::hdr_idx_t'(bram_pkg::HEADER_WORDS - 1);

	logic               active;
	bram_pkg::hdr_idx_t idx;

	// ==============================
	// Header word counter
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			idx    <= '0;
		end else if (format_cmd) begin
			// A new command restarts from word 0
			active <= 1'b1;
			idx    <= '0;
		end else if (active) begin
			idx <= idx + 1'b1;
			if (idx == LAST_IDX)
				active <= 1'b0;  // Done after the last word
		end
	end

	// One port-B write per active cycle
	assign fmt_we   = active;
	assign fmt_addr = bram_pkg::ram_addr_t'(idx);
	assign fmt_data = bram_pkg::format_header[idx];

endmodule

`default_nettype wire

/* save_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module save_fsm (
	input  wire                     clk_sys,
	input  wire                     arst_n,
	input  wire                     start_load,
	input  wire                     start_save,
	input  wire                     ack,
	output bram_pkg::storage_req_t  req,
	output logic                    busy,
	output logic                    loading
);

	localparam bram_pkg::lba_t LAST_LBA =
		bram_pkg::lba_t'(bram_pkg::SECTOR_COUNT - 1);

	bram_pkg::save_state_t state;
	logic                  ack_q;
	logic                  ack_rise;
	logic                  ack_fall;

	// ==============================
	// Handshake edges
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			ack_q <= 1'b0;
		else
			ack_q <= ack;
	end

	assign ack_rise = ack & ~ack_q;
	assign ack_fall = ack_q & ~ack;

	// Any state but idle holds the transfer
	assign busy = (state != bram_pkg::ST_IDLE);

	// ==============================
	// Sector sequencer
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state   <= bram_pkg::ST_IDLE;
			req     <= '0;
			loading <= 1'b0;
		end else begin
			case (state)
				bram_pkg::ST_IDLE: begin
					// Load wins if both arrive together
					if (start_load || start_save) begin
						req.lba <= '0;
						req.rd  <= start_load;
						req.wr  <= !start_load;
						loading <= start_load;
						state   <= bram_pkg::ST_REQUEST;
					end
				end

				bram_pkg::ST_REQUEST: begin
					// Host has taken the sector
					if (ack_rise) begin
						req.rd <= 1'b0;
						req.wr <= 1'b0;
						state  <= bram_pkg::ST_TRANSFER;
					end
				end

				bram_pkg::ST_TRANSFER: begin
					if (ack_fall)
						state <= bram_pkg::ST_NEXT;  // Sector finished
				end

				bram_pkg::ST_NEXT: begin
					if (req.lba == LAST_LBA) begin
						loading <= 1'b0;
						state   <= bram_pkg::ST_IDLE;
					end else begin
						req.lba <= req.lba + 1'b1;
						req.rd  <= loading;
						req.wr  <= !loading;
						state   <= bram_pkg::ST_REQUEST;
					end
				end

				default: begin
					state <= bram_pkg::ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* save_policy.sv */
`timescale 1ns/1ns
`default_nettype none

module save_policy (
	input  wire  clk_sys,
	input  wire  arst_n,
	input  wire  cpu_we,
	input  wire  img_mounted,
	input  wire  img_readonly,
	input  wire  img_present,
	input  wire  cart_download,
	input  wire  osd_open,
	input  wire  autosave_en,
	input  wire  load_cmd,
	input  wire  save_cmd,
	input  wire  busy,
	output logic start_load,
	output logic start_save,
	output logic save_pending
);

	logic enable;   // Writable image mounted
	logic dl_q;
	logic osd_q;
	logic dl_rise;
	logic dl_fall;
	logic osd_rise;

	assign dl_rise  = cart_download & ~dl_q;
	assign dl_fall  = dl_q & ~cart_download;
	assign osd_rise = osd_open & ~osd_q;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_q         <= 1'b0;
			osd_q        <= 1'b0;
			enable       <= 1'b0;
			save_pending <= 1'b0;
			start_load   <= 1'b0;
			start_save   <= 1'b0;
		end else begin
			dl_q  <= cart_download;
			osd_q <= osd_open;

			// Save image is mounted during the cartridge download
			if (cart_download && img_mounted && !img_readonly)
				enable <= 1'b1;
			else if (dl_rise)
				enable <= 1'b0;

			// Console writes with the menu closed mark the RAM dirty
			if (enable && !osd_open && cpu_we)
				save_pending <= 1'b1;
			else if (busy)
				save_pending <= 1'b0;

			// Single-cycle starts, dropped while a transfer runs
			start_save <= enable & ~busy &
				(save_cmd | (osd_rise & autosave_en & save_pending));
			start_load <= enable & ~busy & (load_cmd | (dl_fall & img_present));
		end
	end

endmodule

`default_nettype wire

/* backup_top.sv */
`timescale 1ns/1ns
`default_nettype none

module backup_top (
	input  wire                     clk_sys,
	input  wire                     arst_n,
	input  wire bram_pkg::cpu_bram_t cpu,
	input  wire bram_pkg::host_buf_t host,
	input  wire                     load_cmd,
	input  wire                     save_cmd,
	input  wire                     format_cmd,
	input  wire                     img_mounted,
	input  wire                     img_readonly,
	input  wire                     img_present,
	input  wire                     cart_download,
	input  wire                     osd_open,
	input  wire                     autosave_en,
	output bram_pkg::byte_t         cpu_rdata,
	output bram_pkg::word_t         buff_din,
	output bram_pkg::storage_req_t  req,
	output logic                    busy,
	output logic                    loading,  // Holds the console in reset
	output logic                    save_pending
);

	// ==============================
	// Internal wiring
	// ==============================
	logic                fmt_we;
	bram_pkg::ram_addr_t fmt_addr;
	bram_pkg::word_t     fmt_data;
	logic                start_load;
	logic                start_save;

	backup_ram u_ram (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.cpu       (cpu),
		.cpu_rdata (cpu_rdata),
		.host      (host),
		.lba       (req.lba),
		.fmt_we    (fmt_we),
		.fmt_addr  (fmt_addr),
		.fmt_data  (fmt_data),
		.buff_din  (buff_din)
	);

	format_writer u_format (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.format_cmd (format_cmd),
		.fmt_we     (fmt_we),
		.fmt_addr   (fmt_addr),
		.fmt_data   (fmt_data)
	);

	save_policy u_policy (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.cpu_we        (cpu.we),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_present   (img_present),
		.cart_download (cart_download),
		.osd_open      (osd_open),
		.autosave_en   (autosave_en),
		.load_cmd      (load_cmd),
		.save_cmd      (save_cmd),
		.busy          (busy),
		.start_load    (start_load),
		.start_save    (start_save),
		.save_pending  (save_pending)
	);

	save_fsm u_fsm (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.start_load (start_load),
		.start_save (start_save),
		.ack        (host.ack),
		.req        (req),
		.busy       (busy),
		.loading    (loading)
	);

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk_sys,
	output logic arst_n
);

	localparam int HALF_PERIOD  = 10;  // 20 ns period
	localparam int RESET_CYCLES = 10;

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// Reset released on a rising edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* backup_props.sv */
`timescale 1ns/1ns
`default_nettype none

module backup_props (
	input wire                         clk_sys,
	input wire                         arst_n,
	input wire                         ack,
	input wire bram_pkg::storage_req_t req
);

	logic req_up;

	assign req_up = req.rd | req.wr;

	// Load and save never overlap
	a_one_direction: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(req.rd && req.wr))
		else $error("rd and wr are high together");

	a_req_drop: assert property (@(posedge clk_sys) disable iff (!arst_n)
		req_up && ack |=> !req_up)  // Host took the sector
		else $error("request still up the cycle after ack");

	a_lba_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		req_up |=> !req_up || $stable(req.lba))
		else $error("lba changed while the request was up");

endmodule

bind save_fsm backup_props u_props (
	.clk_sys (clk_sys),
	.arst_n  (arst_n),
	.ack     (ack),
	.req     (req)
);

`default_nettype wire

/* tb_backup.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_backup;

	localparam int CPU_OPS    = 24;
	localparam int WORDS      = 256;  // Words per sector
	localparam int QUIET      = 20;   // Cycles watched for a request that must not come
	localparam int SECTOR_MAX = 2 * WORDS + 8;
	// Reset, CPU passes, three full transfers, quiet windows and slack
	localparam int LIMIT = 10 + 3 * CPU_OPS * 5 + 3 * 16 * SECTOR_MAX + 5 * QUIET + 500;
	localparam logic [15:0] HEADER [4] = '{16'h5548, 16'h4D42, 16'h8800, 16'h8010};

	logic                   clk_sys;
	logic                   arst_n;
	bram_pkg::cpu_bram_t    cpu;
	bram_pkg::host_buf_t    host;
	logic                   load_cmd;
	logic                   save_cmd;
	logic                   format_cmd;
	logic                   img_mounted;
	logic                   img_readonly;
	logic                   img_present;
	logic                   cart_download;
	logic                   osd_open;
	logic                   autosave_en;
	bram_pkg::byte_t        cpu_rdata;
	bram_pkg::word_t        buff_din;
	bram_pkg::storage_req_t req;
	logic                   busy;
	logic                   loading;
	logic                   save_pending;

	logic [31:0]         lcg_state = 32'd6512;
	logic [15:0]         model [1024];  // Sectors 0 to 3, the CPU window
	bram_pkg::cpu_addr_t addrs [CPU_OPS];
	int                  cycle_count = 0;

	tb_clock u_clock (.clk_sys(clk_sys), .arst_n(arst_n));

	backup_top UUT (.*);

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("Simulation FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {16'h0000, lcg_state[31:16]};  // Upper bits are the better ones
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// ==============================
	// Console and command drivers
	// ==============================
	task automatic cpu_write(input bram_pkg::cpu_addr_t addr, input bram_pkg::byte_t data);
		@(posedge clk_sys);
		cpu <= '{addr: addr, wdata: data, we: 1'b1};
		@(posedge clk_sys);
		cpu.we <= 1'b0;
		if (addr[0])
			model[addr[10:1]][15:8] = data;
		else
			model[addr[10:1]][7:0] = data;
	endtask

	task automatic cpu_check(input bram_pkg::cpu_addr_t addr);
		logic [15:0] word;
		@(posedge clk_sys);
		cpu.addr <= addr;
		cpu.we   <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		word = model[addr[10:1]];
		check_value("cpu_rdata", 32'(cpu_rdata), 32'(addr[0] ? word[15:8] : word[7:0]));
	endtask

	task automatic send_cmd(input logic load, input logic save, input logic fmt,
		input logic mount);
		@(posedge clk_sys);
		{load_cmd, save_cmd, format_cmd, img_mounted} <= {load, save, fmt, mount};
		@(posedge clk_sys);
		{load_cmd, save_cmd, format_cmd, img_mounted} <= 4'b0000;
	endtask

	task automatic expect_quiet();
		repeat (QUIET) begin
			@(negedge clk_sys);
			check_value("req.rd|req.wr", 32'(req.rd | req.wr), 32'd0);
		end
	endtask

	// ==============================
	// Storage host
	// ==============================
	task automatic serve_transfer(input logic is_load, input logic poke);
		logic [15:0] w;
		int          base;
		for (int s = 0; s < bram_pkg::SECTOR_COUNT; s++) begin
			@(negedge clk_sys);
			while (!(req.rd || req.wr))
				@(negedge clk_sys);
			check_value("req.lba", 32'(req.lba), 32'(s));
			check_value("req.rd", 32'(req.rd), 32'(is_load));
			check_value("req.wr", 32'(req.wr), 32'(!is_load));
			check_value("loading", 32'(loading), 32'(is_load));
			base = s * WORDS;
			if (poke && s == 0)
				send_cmd(1'b1, 1'b0, 1'b0, 1'b0);  // Load while busy
			@(posedge clk_sys);
			host.ack <= 1'b1;
			if (is_load) begin
				host.buff_wr <= 1'b1;
				for (int i = 0; i < WORDS; i++) begin
					w = 16'(next_random());
					host.buff_addr <= 8'(i);
					host.buff_dout <= w;
					if (s < 4)
						model[10'(base + i)] = w;
					@(posedge clk_sys);
				end
				host.buff_wr <= 1'b0;
			end else if (s < 4) begin
				for (int i = 0; i < WORDS; i++) begin
					host.buff_addr <= 8'(i);
					@(posedge clk_sys);
					@(negedge clk_sys);
					check_value("buff_din", 32'(buff_din), 32'(model[10'(base + i)]));
					@(posedge clk_sys);
				end
			end else begin
				@(posedge clk_sys);  // Handshake only above the CPU window
			end
			host.ack <= 1'b0;
		end
		@(negedge clk_sys);
		while (busy)
			@(negedge clk_sys);
		check_value("loading", 32'(loading), 32'd0);
	endtask

	initial begin
		cpu  <= '0;
		host <= '0;
		{load_cmd, save_cmd, format_cmd, img_mounted} <= 4'b0000;
		{img_readonly, img_present, cart_download, osd_open, autosave_en} <= 5'b00000;
		@(posedge arst_n);
		@(negedge clk_sys);
		check_value("req.rd/req.wr/busy/loading/save_pending",
			32'({req.rd, req.wr, busy, loading, save_pending}), 32'd0);

		for (int i = 0; i < CPU_OPS; i++) begin
			addrs[i] = 11'(next_random());
			cpu_write(addrs[i], 8'(next_random()));
		end
		foreach (addrs[i])
			cpu_check(addrs[i]);

		// Writable image mounted during a download, autoload at its end
		@(posedge clk_sys);
		cart_download <= 1'b1;
		send_cmd(1'b0, 1'b0, 1'b0, 1'b1);
		@(posedge clk_sys);
		img_present   <= 1'b1;
		cart_download <= 1'b0;
		serve_transfer(1'b1, 1'b0);
		for (int i = 0; i < CPU_OPS; i++)
			cpu_check(11'(next_random()));

		for (int i = 0; i < 4; i++)
			cpu_write(11'(next_random()), 8'(next_random()));
		@(negedge clk_sys);
		check_value("save_pending", 32'(save_pending), 32'd1);
		send_cmd(1'b0, 1'b1, 1'b0, 1'b0);
		serve_transfer(1'b0, 1'b1);
		check_value("save_pending", 32'(save_pending), 32'd0);
		expect_quiet();

		// Autosave when the menu opens
		@(posedge clk_sys);
		autosave_en <= 1'b1;
		cpu_write(11'(next_random()), 8'(next_random()));
		@(posedge clk_sys);
		osd_open <= 1'b1;
		serve_transfer(1'b0, 1'b0);
		@(posedge clk_sys);
		osd_open <= 1'b0;
		@(posedge clk_sys);
		osd_open <= 1'b1;  // Nothing pending this time
		expect_quiet();
		@(posedge clk_sys);
		osd_open <= 1'b0;

		send_cmd(1'b0, 1'b0, 1'b1, 1'b0);
		repeat (6) @(posedge clk_sys);
		for (int k = 0; k < 4; k++)
			model[10'(k)] = HEADER[2'(k)];
		for (int b = 0; b < 8; b++)
			cpu_check(11'(b));

		// ==============================
		// Disabled paths
		// ==============================
		@(posedge clk_sys);
		cart_download <= 1'b1;  // New download drops the enable
		repeat (2) @(posedge clk_sys);
		send_cmd(1'b0, 1'b1, 1'b0, 1'b0);
		expect_quiet();
		@(posedge clk_sys);
		img_readonly <= 1'b1;
		send_cmd(1'b0, 1'b0, 1'b0, 1'b1);
		send_cmd(1'b0, 1'b1, 1'b0, 1'b0);
		expect_quiet();
		@(posedge clk_sys);
		cart_download <= 1'b0;  // Image present but not writable
		expect_quiet();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
bram_pkg.sv
backup_ram.sv
format_writer.sv
save_fsm.sv
save_policy.sv
backup_top.sv
tb_clock.sv
backup_props.sv
tb_backup.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --assert -f vlog.f --top-module tb_backup -o sim_backup &&
./obj_dir/sim_backup || exit 1
